/* riscv_defs.svh */
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

//////////////////////////////////////////////////
// Data path and register file
//////////////////////////////////////////////////

`define RISCV_XLEN      32
`define RISCV_AR_BITS   5

// Address of the first accepted parcel
`define RISCV_PC_INIT   'h200

//////////////////////////////////////////////////
// RV32I major opcodes
//////////////////////////////////////////////////

`define RISCV_OPC_OP    7'b0110011
`define RISCV_OPC_OPIMM 7'b0010011
`define RISCV_OPC_LUI   7'b0110111
`define RISCV_OPC_AUIPC 7'b0010111

//////////////////////////////////////////////////
// ALU funct3 values, shared by OP and OP-IMM
//////////////////////////////////////////////////

`define RISCV_F3_ADDSUB 3'b000
`define RISCV_F3_SLL    3'b001
`define RISCV_F3_SLT    3'b010
`define RISCV_F3_SLTU   3'b011
`define RISCV_F3_XOR    3'b100
`define RISCV_F3_SR     3'b101
`define RISCV_F3_OR     3'b110
`define RISCV_F3_AND    3'b111

// Bit of funct7 that turns ADD into SUB and SRL into SRA
`define RISCV_F7_ALT_BIT 5

`endif

/* riscv_pkg.sv */
`include "riscv_defs.svh"

package riscv_pkg;

  //////////////////////////////////////////////////
  // Data path types
  //////////////////////////////////////////////////

  // One integer data word
  typedef logic [`RISCV_XLEN-1:0] xlen_t;

  // Register number, x0 to x31
  typedef logic [`RISCV_AR_BITS-1:0] reg_addr_t;

  // One 32-bit instruction parcel
  typedef logic [31:0] instr_t;

  //////////////////////////////////////////////////
  // ALU function select
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_SLL   = 4'd2,
    ALU_SLT   = 4'd3,
    ALU_SLTU  = 4'd4,
    ALU_XOR   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_OR    = 4'd8,
    ALU_AND   = 4'd9,
    // Forward operand B untouched, for LUI
    ALU_PASSB = 4'd10
  } alu_op_e;

endpackage

/* riscv_if.sv */
`timescale 1ns/1ps

`include "riscv_defs.svh"

module riscv_if (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Parcel strobe, no back-pressure
  input  riscv_pkg::instr_t if_parcel_i,
  input  logic              if_parcel_valid_i,

  // Fetch register towards decode
  output riscv_pkg::instr_t if_instr_o,
  output riscv_pkg::xlen_t  if_pc_o,
  output logic              if_valid_o
);

  // Address of the next parcel to be accepted
  riscv_pkg::xlen_t pc;

  //////////////////////////////////////////////////
  // Program counter and valid
  //////////////////////////////////////////////////

  // No branches, so the counter only moves forward
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc         <= `RISCV_PC_INIT;
      if_valid_o <= 1'b0;
    end else begin
      if_valid_o <= if_parcel_valid_i;
      if (if_parcel_valid_i) begin
        pc <= pc + 32'd4;
      end
    end
  end

  //////////////////////////////////////////////////
  // Parcel register
  //////////////////////////////////////////////////

  // Parcel travels with the PC it was fetched at
  always_ff @(posedge clk_i) begin
    if (if_parcel_valid_i) begin
      if_instr_o <= if_parcel_i;
      if_pc_o    <= pc;
    end
  end

endmodule

/* riscv_rf.sv */
`timescale 1ns/1ps

`include "riscv_defs.svh"

module riscv_rf (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Read ports, answered in the same cycle
  input  riscv_pkg::reg_addr_t rf_src1_i,
  input  riscv_pkg::reg_addr_t rf_src2_i,
  output riscv_pkg::xlen_t     rf_srcv1_o,
  output riscv_pkg::xlen_t     rf_srcv2_o,

  // Write port from write-back
  input  logic                 rf_we_i,
  input  riscv_pkg::reg_addr_t rf_dst_i,
  input  riscv_pkg::xlen_t     rf_dstv_i
);

  localparam int NUM_REGS = 1 << `RISCV_AR_BITS;

  riscv_pkg::xlen_t regs [NUM_REGS];

  // x0 is never a write target, so it keeps its reset zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we_i) begin
      regs[rf_dst_i] <= rf_dstv_i;
    end
  end

  // Combinational read
  assign rf_srcv1_o = regs[rf_src1_i];
  assign rf_srcv2_o = regs[rf_src2_i];

endmodule

/* riscv_id.sv */
`timescale 1ns/1ps

`include "riscv_defs.svh"

module riscv_id (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // From fetch
  input  riscv_pkg::instr_t    if_instr_i,
  input  riscv_pkg::xlen_t     if_pc_i,
  input  logic                 if_valid_i,

  // Register file read
  output riscv_pkg::reg_addr_t rf_src1_o,
  output riscv_pkg::reg_addr_t rf_src2_o,
  input  riscv_pkg::xlen_t     rf_srcv1_i,
  input  riscv_pkg::xlen_t     rf_srcv2_i,

  // Bypass sources
  input  riscv_pkg::xlen_t     ex_r_i,
  input  logic                 wb_valid_i,
  input  riscv_pkg::reg_addr_t wb_dst_i,
  input  riscv_pkg::xlen_t     wb_r_i,

  // Towards execute
  output logic                 id_valid_o,
  output riscv_pkg::alu_op_e   id_op_o,
  output riscv_pkg::xlen_t     id_opa_o,
  output riscv_pkg::xlen_t     id_opb_o,
  output riscv_pkg::reg_addr_t id_dst_o
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic                 alt;
  riscv_pkg::reg_addr_t rs1;
  riscv_pkg::reg_addr_t rs2;
  riscv_pkg::reg_addr_t rd;
  riscv_pkg::xlen_t     imm_i;
  riscv_pkg::xlen_t     imm_u;
  riscv_pkg::xlen_t     src1_val;
  riscv_pkg::xlen_t     src2_val;
  riscv_pkg::alu_op_e   f3_op;
  riscv_pkg::alu_op_e   op;
  riscv_pkg::xlen_t     opa;
  riscv_pkg::xlen_t     opb;
  logic                 supported;

  // Copy of the instruction now sitting in execute
  logic                 ex_valid;
  riscv_pkg::reg_addr_t ex_dst;

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////

  assign opcode = if_instr_i[6:0];
  assign rd     = if_instr_i[11:7];
  assign funct3 = if_instr_i[14:12];
  assign rs1    = if_instr_i[19:15];
  assign rs2    = if_instr_i[24:20];
  assign funct7 = if_instr_i[31:25];
  assign alt    = funct7[`RISCV_F7_ALT_BIT];

  assign imm_i = {{(`RISCV_XLEN-12){if_instr_i[31]}}, if_instr_i[31:20]};
  assign imm_u = {if_instr_i[31:12], 12'b0};

  assign rf_src1_o = rs1;
  assign rf_src2_o = rs2;

  //////////////////////////////////////////////////
  // Operand bypass
  //////////////////////////////////////////////////

  // Newest value wins: execute, then write-back, then register file
  assign src1_val = (rs1 == '0)                    ? '0     :
                    (ex_valid && ex_dst == rs1)     ? ex_r_i :
                    (wb_valid_i && wb_dst_i == rs1) ? wb_r_i : rf_srcv1_i;
  assign src2_val = (rs2 == '0)                    ? '0     :
                    (ex_valid && ex_dst == rs2)     ? ex_r_i :
                    (wb_valid_i && wb_dst_i == rs2) ? wb_r_i : rf_srcv2_i;

  // funct3 map, SUB only exists in the register form
  always_comb begin
    case (funct3)
      `RISCV_F3_ADDSUB: f3_op = (alt && opcode == `RISCV_OPC_OP) ? riscv_pkg::ALU_SUB
                                                                 : riscv_pkg::ALU_ADD;
      `RISCV_F3_SLL:    f3_op = riscv_pkg::ALU_SLL;
      `RISCV_F3_SLT:    f3_op = riscv_pkg::ALU_SLT;
      `RISCV_F3_SLTU:   f3_op = riscv_pkg::ALU_SLTU;
      `RISCV_F3_XOR:    f3_op = riscv_pkg::ALU_XOR;
      `RISCV_F3_SR:     f3_op = alt ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
      `RISCV_F3_OR:     f3_op = riscv_pkg::ALU_OR;
      default:          f3_op = riscv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    op        = f3_op;
    opa       = src1_val;
    opb       = src2_val;
    supported = 1'b1;
    case (opcode)
      `RISCV_OPC_OP:    ;
      `RISCV_OPC_OPIMM: opb = imm_i;
      `RISCV_OPC_LUI: begin
        op  = riscv_pkg::ALU_PASSB;
        opb = imm_u;
      end
      `RISCV_OPC_AUIPC: begin
        op  = riscv_pkg::ALU_ADD;
        opa = if_pc_i;
        opb = imm_u;
      end
      default: supported = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Decode register
  //////////////////////////////////////////////////

  // Unsupported opcodes and writes to x0 become bubbles
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= if_valid_i && supported && (rd != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (if_valid_i) begin
      id_op_o  <= op;
      id_opa_o <= opa;
      id_opb_o <= opb;
      ex_dst   <= rd;
    end
  end

  assign id_valid_o = ex_valid;
  assign id_dst_o   = ex_dst;

endmodule

/* riscv_ex.sv */
`timescale 1ns/1ps

`include "riscv_defs.svh"

module riscv_ex (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // From decode
  input  logic                 id_valid_i,
  input  riscv_pkg::alu_op_e   id_op_i,
  input  riscv_pkg::xlen_t     id_opa_i,
  input  riscv_pkg::xlen_t     id_opb_i,
  input  riscv_pkg::reg_addr_t id_dst_i,

  // Execute bypass, same cycle
  output riscv_pkg::xlen_t     ex_r_o,

  // Write-back register
  output logic                 wb_valid_o,
  output riscv_pkg::reg_addr_t wb_dst_o,
  output riscv_pkg::xlen_t     wb_r_o
);

  localparam int SHAMT_W = $clog2(`RISCV_XLEN);

  logic [SHAMT_W-1:0] shamt;
  riscv_pkg::xlen_t   alu_r;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  // Only the low bits of operand B count as shift amount
  assign shamt = id_opb_i[SHAMT_W-1:0];

  always_comb begin
    case (id_op_i)
      riscv_pkg::ALU_ADD:   alu_r = id_opa_i + id_opb_i;
      riscv_pkg::ALU_SUB:   alu_r = id_opa_i - id_opb_i;
      riscv_pkg::ALU_SLL:   alu_r = id_opa_i << shamt;
      riscv_pkg::ALU_SLT:
        alu_r = riscv_pkg::xlen_t'($signed(id_opa_i) < $signed(id_opb_i));
      riscv_pkg::ALU_SLTU:  alu_r = riscv_pkg::xlen_t'(id_opa_i < id_opb_i);
      riscv_pkg::ALU_XOR:   alu_r = id_opa_i ^ id_opb_i;
      riscv_pkg::ALU_SRL:   alu_r = id_opa_i >> shamt;
      riscv_pkg::ALU_SRA:   alu_r = $signed(id_opa_i) >>> shamt;
      riscv_pkg::ALU_OR:    alu_r = id_opa_i | id_opb_i;
      riscv_pkg::ALU_AND:   alu_r = id_opa_i & id_opb_i;
      riscv_pkg::ALU_PASSB: alu_r = id_opb_i;
      default:              alu_r = '0;
    endcase
  end

  assign ex_r_o = alu_r;

  //////////////////////////////////////////////////
  // Write-back register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= id_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_valid_i) begin
      wb_dst_o <= id_dst_i;
      wb_r_o   <= alu_r;
    end
  end

endmodule

/* riscv_core.sv */
`timescale 1ns/1ps

module riscv_core (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Instruction strobe
  input  riscv_pkg::instr_t    if_parcel_i,
  input  logic                 if_parcel_valid_i,

  // Results, in issue order
  output logic                 wb_valid_o,
  output riscv_pkg::reg_addr_t wb_dst_o,
  output riscv_pkg::xlen_t     wb_r_o
);

  // Fetch to decode
  riscv_pkg::instr_t    if_instr;
  riscv_pkg::xlen_t     if_pc;
  logic                 if_valid;

  // Decode to register file
  riscv_pkg::reg_addr_t rf_src1;
  riscv_pkg::reg_addr_t rf_src2;
  riscv_pkg::xlen_t     rf_srcv1;
  riscv_pkg::xlen_t     rf_srcv2;

  // Decode to execute
  logic                 id_valid;
  riscv_pkg::alu_op_e   id_op;
  riscv_pkg::xlen_t     id_opa;
  riscv_pkg::xlen_t     id_opb;
  riscv_pkg::reg_addr_t id_dst;

  // Execute bypass
  riscv_pkg::xlen_t     ex_r;

  //////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////

  riscv_if u_if (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .if_parcel_i       ( if_parcel_i       ),
    .if_parcel_valid_i ( if_parcel_valid_i ),
    .if_instr_o        ( if_instr          ),
    .if_pc_o           ( if_pc             ),
    .if_valid_o        ( if_valid          )
  );

  riscv_id u_id (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .if_instr_i ( if_instr   ),
    .if_pc_i    ( if_pc      ),
    .if_valid_i ( if_valid   ),
    .rf_src1_o  ( rf_src1    ),
    .rf_src2_o  ( rf_src2    ),
    .rf_srcv1_i ( rf_srcv1   ),
    .rf_srcv2_i ( rf_srcv2   ),
    .ex_r_i     ( ex_r       ),
    .wb_valid_i ( wb_valid_o ),
    .wb_dst_i   ( wb_dst_o   ),
    .wb_r_i     ( wb_r_o     ),
    .id_valid_o ( id_valid   ),
    .id_op_o    ( id_op      ),
    .id_opa_o   ( id_opa     ),
    .id_opb_o   ( id_opb     ),
    .id_dst_o   ( id_dst     )
  );

  riscv_ex u_ex (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .id_valid_i ( id_valid   ),
    .id_op_i    ( id_op      ),
    .id_opa_i   ( id_opa     ),
    .id_opb_i   ( id_opb     ),
    .id_dst_i   ( id_dst     ),
    .ex_r_o     ( ex_r       ),
    .wb_valid_o ( wb_valid_o ),
    .wb_dst_o   ( wb_dst_o   ),
    .wb_r_o     ( wb_r_o     )
  );

  // Integer register file, written straight from write-back
  riscv_rf u_rf (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .rf_src1_i  ( rf_src1    ),
    .rf_src2_i  ( rf_src2    ),
    .rf_srcv1_o ( rf_srcv1   ),
    .rf_srcv2_o ( rf_srcv2   ),
    .rf_we_i    ( wb_valid_o ),
    .rf_dst_i   ( wb_dst_o   ),
    .rf_dstv_i  ( wb_r_o     )
  );

endmodule

/* tb_riscv_core.sv */
`timescale 1ns/1ps

`include "riscv_defs.svh"

module tb_riscv_core;

  localparam int N_INIT     = 62;
  localparam int N_DIRECTED = 12;
  localparam int N_RAND     = 400;
  // Each parcel takes at most 4 cycles including its gap
  localparam int TIMEOUT_NS = (N_INIT + N_DIRECTED + N_RAND) * 4 * 8 + 1000;

  logic                 clk_i;
  logic                 rst_n_i;
  riscv_pkg::instr_t    if_parcel_i;
  logic                 if_parcel_valid_i;
  logic                 wb_valid_o;
  riscv_pkg::reg_addr_t wb_dst_o;
  riscv_pkg::xlen_t     wb_r_o;

  logic [31:0] rng;
  logic [31:0] regs_m [32];
  logic [31:0] pc_m;
  int          cyc;
  int          errors;
  int          checks;

  // Expected write-backs in issue order
  logic [4:0]  exp_dst_q [$];
  logic [31:0] exp_val_q [$];
  int          exp_cyc_q [$];
  string       exp_name_q [$];

  riscv_core u_dut (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .if_parcel_i       ( if_parcel_i       ),
    .if_parcel_valid_i ( if_parcel_valid_i ),
    .wb_valid_o        ( wb_valid_o        ),
    .wb_dst_o          ( wb_dst_o          ),
    .wb_r_o            ( wb_r_o            )
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  //////////////////////////////////////////////////
  // Reference rules and stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Mostly back to back, sometimes up to 3 idle cycles
  function automatic int pick_gap();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] != 2'b11) return 0;
    return int'(r[3:2]);
  endfunction

  // RV32I integer result for a funct3 and the alternate bit
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      `RISCV_F3_ADDSUB: return alt ? a - b : a + b;
      `RISCV_F3_SLL:    return a << sh;
      `RISCV_F3_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `RISCV_F3_SLTU:   return (a < b) ? 32'd1 : 32'd0;
      `RISCV_F3_XOR:    return a ^ b;
      `RISCV_F3_SR: begin
        if (alt) return $signed(a) >>> sh;
        return a >> sh;
      end
      `RISCV_F3_OR:     return a | b;
      default:          return a & b;
    endcase
  endfunction

  // Strobe one parcel and record what write-back it must cause
  task automatic send(input logic [31:0] instr, input logic has_res, input logic [4:0] dst,
                      input logic [31:0] val, input int gap, input string name);
    @(posedge clk_i);
    #1;
    if_parcel_i       = instr;
    if_parcel_valid_i = 1'b1;
    pc_m              = pc_m + 32'd4;
    if (has_res && dst != 5'd0) begin
      regs_m[dst] = val;
      exp_dst_q.push_back(dst);
      exp_val_q.push_back(val);
      exp_cyc_q.push_back(cyc + 3);
      exp_name_q.push_back(name);
    end
    repeat (gap) begin
      @(posedge clk_i);
      #1;
      if_parcel_valid_i = 1'b0;
      if_parcel_i       = next_rand();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      if_parcel_valid_i = 1'b0;
      if_parcel_i       = next_rand();
    end
  endtask

  task automatic rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd, rs1, rs2,
                    input int gap, input string name);
    logic        use_alt;
    logic [31:0] v;
    use_alt = alt && (f3 == `RISCV_F3_ADDSUB || f3 == `RISCV_F3_SR);
    v = alu_ref(f3, use_alt, regs_m[rs1], regs_m[rs2]);
    send({1'b0, use_alt, 5'b0, rs2, rs1, f3, rd, `RISCV_OPC_OP}, 1'b1, rd, v, gap, name);
  endtask

  task automatic ri(input logic [2:0] f3, input logic [4:0] rd, rs1, input logic [11:0] imm,
                    input int gap, input string name);
    logic [11:0] enc;
    logic        alt;
    logic [31:0] v;
    enc = imm;
    alt = 1'b0;
    if (f3 == `RISCV_F3_SLL) enc = {7'b0, imm[4:0]};
    if (f3 == `RISCV_F3_SR) begin
      alt = imm[10];
      enc = {1'b0, imm[10], 5'b0, imm[4:0]};
    end
    v = alu_ref(f3, alt, regs_m[rs1], {{20{enc[11]}}, enc});
    send({enc, rs1, f3, rd, `RISCV_OPC_OPIMM}, 1'b1, rd, v, gap, name);
  endtask

  task automatic lui(input logic [4:0] rd, input logic [19:0] imm, input int gap);
    send({imm, rd, `RISCV_OPC_LUI}, 1'b1, rd, {imm, 12'b0}, gap, "lui");
  endtask

  // PC of this parcel is the model counter before send moves it
  task automatic auipc(input logic [4:0] rd, input logic [19:0] imm, input int gap);
    send({imm, rd, `RISCV_OPC_AUIPC}, 1'b1, rd, pc_m + {imm, 12'b0}, gap, "auipc");
  endtask

  task automatic send_bad(input logic [31:0] r, input int gap);
    logic [6:0] opc;
    case (r[13:12])
      2'd0:    opc = 7'b0000011;
      2'd1:    opc = 7'b0100011;
      2'd2:    opc = 7'b1100011;
      default: opc = 7'b1101111;
    endcase
    send({r[31:7], opc}, 1'b0, 5'd0, 32'd0, gap, "bad_opcode");
  endtask

  task automatic send_random();
    logic [31:0] r;
    logic [31:0] r2;
    int          gap;
    r   = next_rand();
    r2  = next_rand();
    gap = pick_gap();
    case (r[3:0])
      4'd11:   lui(r[8:4], r2[31:12], gap);
      4'd12:   auipc(r[8:4], r2[31:12], gap);
      4'd13:   send_bad(r2, gap);
      4'd14:   rr(r[22:20], r[23], 5'd0, r[13:9], r[18:14], gap, "x0_dst");
      4'd6, 4'd7, 4'd8, 4'd9, 4'd10:
        ri(r[22:20], r[8:4], r[13:9], r2[11:0], gap, "reg_imm");
      default: rr(r[22:20], r[23], r[8:4], r[13:9], r[18:14], gap, "reg_reg");
    endcase
  endtask

  //////////////////////////////////////////////////
  // Write-back checks
  //////////////////////////////////////////////////

  // Sampled mid-cycle, away from the clock edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (wb_valid_o) begin
        assert (exp_dst_q.size() > 0) else begin
          $display("Unexpected write-back to x%0d with nothing outstanding", wb_dst_o);
          errors++;
        end
        if (exp_dst_q.size() > 0) begin
          checks++;
          assert (wb_dst_o == exp_dst_q[0]) else begin
            $display("Fail %s dst: expected %0d actual %0d", exp_name_q[0], exp_dst_q[0],
                     wb_dst_o);
            errors++;
          end
          assert (wb_r_o == exp_val_q[0]) else begin
            $display("Fail %s value: expected %h actual %h", exp_name_q[0], exp_val_q[0],
                     wb_r_o);
            errors++;
          end
          assert (cyc == exp_cyc_q[0]) else begin
            $display("Fail %s cycle: expected %0d actual %0d", exp_name_q[0], exp_cyc_q[0],
                     cyc);
            errors++;
          end
          void'(exp_dst_q.pop_front());
          void'(exp_val_q.pop_front());
          void'(exp_cyc_q.pop_front());
          void'(exp_name_q.pop_front());
        end
      end else if (exp_cyc_q.size() > 0) begin
        assert (exp_cyc_q[0] > cyc) else begin
          $display("Missing write-back of %s to x%0d due at cycle %0d", exp_name_q[0],
                   exp_dst_q[0], exp_cyc_q[0]);
          errors++;
          void'(exp_dst_q.pop_front());
          void'(exp_val_q.pop_front());
          void'(exp_cyc_q.pop_front());
          void'(exp_name_q.pop_front());
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk_i             = 1'b0;
    rst_n_i           = 1'b0;
    if_parcel_i       = '0;
    if_parcel_valid_i = 1'b0;
    rng               = 32'd92967;
    pc_m              = `RISCV_PC_INIT;
    errors            = 0;
    checks            = 0;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = 32'd0;
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // Nothing strobed yet, so no write-back may show
    idle(10);

    // Load every register, ADDI right behind its LUI
    for (int i = 1; i < 32; i++) begin
      lui(5'(i), 20'(next_rand() >> 12), 0);
      ri(`RISCV_F3_ADDSUB, 5'(i), 5'(i), 12'(next_rand()), pick_gap(), "init_addi");
    end

    // Dependency chain at distances one, two, three and beyond
    ri(`RISCV_F3_ADDSUB, 5'd7, 5'd7, 12'h123, 0, "bypass");
    ri(`RISCV_F3_ADDSUB, 5'd7, 5'd7, 12'hfff, 0, "bypass");
    rr(`RISCV_F3_ADDSUB, 1'b1, 5'd9, 5'd3, 5'd7, 1, "bypass");
    rr(`RISCV_F3_XOR, 1'b0, 5'd7, 5'd9, 5'd7, 2, "bypass");
    rr(`RISCV_F3_ADDSUB, 1'b0, 5'd9, 5'd7, 5'd9, 3, "bypass");
    ri(`RISCV_F3_SLTU, 5'd10, 5'd9, 12'h800, 0, "sltiu");
    // Writes to x0 vanish and x0 still reads zero
    ri(`RISCV_F3_ADDSUB, 5'd0, 5'd3, 12'h055, 0, "x0_dst");
    rr(`RISCV_F3_OR, 1'b0, 5'd11, 5'd0, 5'd0, 0, "x0_read");
    send_bad(next_rand(), 0);
    auipc(5'd12, 20'h12345, 0);
    ri(`RISCV_F3_SR, 5'd13, 5'd12, 12'h41f, 0, "srai");
    lui(5'd14, 20'hfffff, 0);

    for (int n = 0; n < N_RAND; n++) begin
      send_random();
    end
    idle(10);

    assert (exp_dst_q.size() == 0) else begin
      $display("%0d expected write-backs never arrived", exp_dst_q.size());
      errors++;
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout, run did not finish within %0d ns", TIMEOUT_NS);
    $display("Checks %0d, errors %0d", checks, errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* list.f */
+incdir+.
riscv_pkg.sv
riscv_if.sv
riscv_rf.sv
riscv_id.sv
riscv_ex.sv
riscv_core.sv
tb_riscv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' list.f)
HDRS := $(wildcard *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f list.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
